// File: sata_cmd_pkg.sv
// Shared widths, FIFO sizing, opcodes, register bit positions and control enums
`default_nettype none

package sata_cmd_pkg;

  // Data path and register field widths
  localparam int DATA_W  = 32;
  localparam int LBA_W   = 48;
  localparam int COUNT_W = 16;
  localparam int BYTE_W  = 8;

  // FIFO sizing, depth must be a power of two
  localparam int FIFO_DEPTH = 16;
  localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
  localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);
  localparam logic [FIFO_CW-1:0] FIFO_FULL = FIFO_CW'(FIFO_DEPTH);

  // Settling after reset or SRST assertion
  localparam int SETTLE_CYCLES = 2;
  localparam int SETTLE_W      = $clog2(SETTLE_CYCLES + 1);
  localparam logic [SETTLE_W-1:0] SETTLE_COUNT = SETTLE_W'(SETTLE_CYCLES);

  // ATA opcodes
  localparam logic [BYTE_W-1:0] CMD_DMA_READ_EXT  = 8'h25;
  localparam logic [BYTE_W-1:0] CMD_DMA_WRITE_EXT = 8'h35;

  // Control and status register bits
  localparam int CONTROL_SRST_BIT = 2;
  localparam int STATUS_ERR_BIT   = 0;
  localparam int STATUS_BSY_BIT   = 7;

  typedef enum logic [2:0] {
    CTL_IDLE,
    CTL_READ_WAIT,
    CTL_WRITE_WAIT_ACT,
    CTL_WRITE_DATA,
    CTL_WRITE_SEND
  } ctl_state_t;

  typedef enum logic [1:0] {
    CMD_USER,
    CMD_READ,
    CMD_WRITE
  } cmd_kind_t;

endpackage

`default_nettype wire

// File: sata_data_fifo.sv
// Single-clock register FIFO with valid/ready on both sides and gated drain valid
`timescale 1ns/1ps
`default_nettype none

module sata_data_fifo (
  input  logic                            clk,
  input  logic                            reset_timeout,
  input  logic                            in_valid,
  input  logic [sata_cmd_pkg::DATA_W-1:0] in_data,
  input  logic                            drain_enable,
  input  logic                            out_ready,
  output logic                            in_ready,
  output logic                            out_valid,
  output logic [sata_cmd_pkg::DATA_W-1:0] out_data,
  output logic                            empty
);

  logic [sata_cmd_pkg::DATA_W-1:0]  mem [sata_cmd_pkg::FIFO_DEPTH];
  logic [sata_cmd_pkg::FIFO_AW-1:0] wr_ptr;
  logic [sata_cmd_pkg::FIFO_AW-1:0] rd_ptr;
  logic [sata_cmd_pkg::FIFO_CW-1:0] count;
  logic                             push;
  logic                             pop;

  assign empty     = (count == '0);
  assign in_ready  = (count != sata_cmd_pkg::FIFO_FULL);
  // Drain side only offers data while enabled
  assign out_valid = !empty && drain_enable;
  assign out_data  = mem[rd_ptr];

  assign push = in_valid && in_ready;
  assign pop  = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= in_data;
    end
  end

  // Pointers wrap on their own
  always_ff @(posedge clk) begin
    if (!reset_timeout) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: sata_fis_regs.sv
// Host-to-device register fields, first-transfer LBA tracking and device status capture
`timescale 1ns/1ps
`default_nettype none

module sata_fis_regs (
  input  logic                             clk,
  input  logic                             reset_timeout,
  input  logic                             load_cmd,
  input  sata_cmd_pkg::cmd_kind_t          cmd_kind,
  input  logic                             srst,
  input  logic                             read_first_done,
  input  logic                             write_first_done,
  input  logic                             read_data_en,
  input  logic                             write_data_en,
  input  logic                             single_rdwr,
  input  logic [sata_cmd_pkg::BYTE_W-1:0]  command,
  input  logic [sata_cmd_pkg::COUNT_W-1:0] user_features,
  input  logic [sata_cmd_pkg::COUNT_W-1:0] sector_count,
  input  logic [sata_cmd_pkg::LBA_W-1:0]   sector_address,
  input  logic [sata_cmd_pkg::LBA_W-1:0]   d2h_lba,
  input  logic [sata_cmd_pkg::BYTE_W-1:0]  d2h_status,
  input  logic                             t_d2h_reg_stb,
  input  logic                             t_set_device_bits_stb,
  output logic [sata_cmd_pkg::BYTE_W-1:0]  h2d_command,
  output logic [sata_cmd_pkg::COUNT_W-1:0] h2d_features,
  output logic [sata_cmd_pkg::BYTE_W-1:0]  h2d_control,
  output logic [sata_cmd_pkg::LBA_W-1:0]   h2d_lba,
  output logic [sata_cmd_pkg::COUNT_W-1:0] h2d_sector_count,
  output logic [sata_cmd_pkg::BYTE_W-1:0]  device_status,
  output logic                             dev_error
);

  logic                            first_read;
  logic                            first_write;
  logic [sata_cmd_pkg::BYTE_W-1:0] sdb_status;

  // Continuous transfers pick up where the device stopped
  always_ff @(posedge clk) begin
    if (load_cmd) begin
      h2d_sector_count <= sector_count;
      case (cmd_kind)
        sata_cmd_pkg::CMD_READ: begin
          h2d_command  <= sata_cmd_pkg::CMD_DMA_READ_EXT;
          h2d_features <= '0;
          h2d_lba      <= (!single_rdwr && !first_read) ? d2h_lba + 1'b1 : sector_address;
        end
        sata_cmd_pkg::CMD_WRITE: begin
          h2d_command  <= sata_cmd_pkg::CMD_DMA_WRITE_EXT;
          h2d_features <= '0;
          h2d_lba      <= (!single_rdwr && !first_write) ? d2h_lba + 1'b1 : sector_address;
        end
        default: begin
          h2d_command  <= command;
          h2d_features <= user_features;
          h2d_lba      <= sector_address;
        end
      endcase
    end
  end

  // SDB FIS leaves BSY alone
  always_comb begin
    sdb_status = d2h_status;
    sdb_status[sata_cmd_pkg::STATUS_BSY_BIT] = device_status[sata_cmd_pkg::STATUS_BSY_BIT];
  end

  always_ff @(posedge clk) begin
    if (!reset_timeout) begin
      first_read    <= 1'b1;
      first_write   <= 1'b1;
      h2d_control   <= '0;
      device_status <= '0;
    end else begin
      if (!read_data_en) begin
        first_read <= 1'b1;
      end else if (read_first_done) begin
        first_read <= 1'b0;
      end
      if (!write_data_en) begin
        first_write <= 1'b1;
      end else if (write_first_done) begin
        first_write <= 1'b0;
      end
      h2d_control <= '0;
      h2d_control[sata_cmd_pkg::CONTROL_SRST_BIT] <= srst;
      if (t_d2h_reg_stb) begin
        device_status <= d2h_status;
      end else if (t_set_device_bits_stb) begin
        device_status <= sdb_status;
      end
    end
  end

  assign dev_error = device_status[sata_cmd_pkg::STATUS_ERR_BIT];

endmodule

`default_nettype wire

// File: sata_cmd_control.sv
// Command layer FSM with DMA sequencing, soft reset, settling, busy and sync escape
`timescale 1ns/1ps
`default_nettype none

module sata_cmd_control (
  input  logic                     clk,
  input  logic                     reset_timeout,
  input  logic                     transport_layer_ready,
  input  logic                     send_user_command,
  input  logic                     read_data_en,
  input  logic                     write_data_en,
  input  logic                     single_rdwr,
  input  logic                     soft_reset_en,
  input  logic                     send_sync_escape,
  input  logic                     t_dma_activate_stb,
  input  logic                     t_d2h_reg_stb,
  input  logic                     t_d2h_data_stb,
  input  logic                     write_fifo_empty,
  output sata_cmd_pkg::ctl_state_t state,
  output logic                     load_cmd,
  output sata_cmd_pkg::cmd_kind_t  cmd_kind,
  output logic                     srst,
  output logic                     read_first_done,
  output logic                     write_first_done,
  output logic                     drain_enable,
  output logic                     settle_done,
  output logic                     command_layer_ready,
  output logic                     busy,
  output logic                     sync_escape,
  output logic                     t_send_command_stb,
  output logic                     t_send_control_stb,
  output logic                     t_send_data_stb
);

  logic [sata_cmd_pkg::SETTLE_W-1:0] settle_cnt;
  logic                              srst_prev;
  logic                              user_cmd_prev;
  logic                              single_read_prev;
  logic                              single_write_prev;
  logic                              dma_act_seen;
  logic                              seen_data;
  logic                              cmd_ok;
  logic                              user_go;
  logic                              read_go;
  logic                              write_go;

  assign settle_done = (settle_cnt == sata_cmd_pkg::SETTLE_COUNT);

  assign command_layer_ready = (state == sata_cmd_pkg::CTL_IDLE) && settle_done && !srst &&
                               transport_layer_ready;

  // No new request while a soft reset or sync escape is pending
  assign cmd_ok   = command_layer_ready && !soft_reset_en && !send_sync_escape;
  assign user_go  = cmd_ok && send_user_command && !user_cmd_prev;
  assign read_go  = cmd_ok && !user_go && read_data_en && !(single_rdwr && single_read_prev);
  assign write_go = cmd_ok && !user_go && !read_go && write_data_en &&
                    !(single_rdwr && single_write_prev);

  assign load_cmd = user_go || read_go || write_go;

  always_comb begin
    if (read_go) begin
      cmd_kind = sata_cmd_pkg::CMD_READ;
    end else if (write_go) begin
      cmd_kind = sata_cmd_pkg::CMD_WRITE;
    end else begin
      cmd_kind = sata_cmd_pkg::CMD_USER;
    end
  end

  assign read_first_done  = (state == sata_cmd_pkg::CTL_READ_WAIT) && t_d2h_data_stb;
  assign write_first_done = (state == sata_cmd_pkg::CTL_WRITE_WAIT_ACT) && dma_act_seen;

  always_ff @(posedge clk) begin
    if (!reset_timeout) begin
      state              <= sata_cmd_pkg::CTL_IDLE;
      settle_cnt         <= '0;
      srst               <= 1'b0;
      srst_prev          <= 1'b0;
      user_cmd_prev      <= 1'b0;
      single_read_prev   <= 1'b0;
      single_write_prev  <= 1'b0;
      dma_act_seen       <= 1'b0;
      seen_data          <= 1'b0;
      drain_enable       <= 1'b0;
      busy               <= 1'b0;
      sync_escape        <= 1'b0;
      t_send_command_stb <= 1'b0;
      t_send_control_stb <= 1'b0;
      t_send_data_stb    <= 1'b0;
    end else begin
      t_send_command_stb <= load_cmd;
      t_send_data_stb    <= 1'b0;
      sync_escape        <= 1'b0;
      // Control FIS follows every SRST change by one cycle
      srst_prev          <= srst;
      t_send_control_stb <= srst ^ srst_prev;

      if (!settle_done) begin
        settle_cnt <= settle_cnt + 1'b1;
      end
      if (!send_user_command) begin
        user_cmd_prev <= 1'b0;
      end
      if (!read_data_en) begin
        single_read_prev <= 1'b0;
      end
      if (!write_data_en) begin
        single_write_prev <= 1'b0;
      end
      if (t_dma_activate_stb) begin
        dma_act_seen <= 1'b1;
      end
      if (t_d2h_reg_stb) begin
        busy <= 1'b0;
      end
      if (load_cmd) begin
        busy <= 1'b1;
      end

      case (state)
        sata_cmd_pkg::CTL_IDLE: begin
          if (soft_reset_en && !srst) begin
            srst       <= 1'b1;
            settle_cnt <= '0;
          end else if (!soft_reset_en && srst && settle_done && transport_layer_ready) begin
            srst <= 1'b0;
          end
          if (user_go) begin
            user_cmd_prev <= 1'b1;
          end
          if (read_go) begin
            single_read_prev <= 1'b1;
            state            <= sata_cmd_pkg::CTL_READ_WAIT;
          end
          if (write_go) begin
            single_write_prev <= 1'b1;
            dma_act_seen      <= 1'b0;
            state             <= sata_cmd_pkg::CTL_WRITE_WAIT_ACT;
          end
        end
        sata_cmd_pkg::CTL_READ_WAIT: begin
          // Left on the device's register FIS below
        end
        sata_cmd_pkg::CTL_WRITE_WAIT_ACT: begin
          if (dma_act_seen) begin
            dma_act_seen <= 1'b0;
            seen_data    <= 1'b0;
            drain_enable <= 1'b1;
            state        <= sata_cmd_pkg::CTL_WRITE_DATA;
          end
        end
        sata_cmd_pkg::CTL_WRITE_DATA: begin
          if (!write_fifo_empty) begin
            seen_data <= 1'b1;
          end
          if (seen_data && write_fifo_empty) begin
            drain_enable <= 1'b0;
            state        <= sata_cmd_pkg::CTL_WRITE_SEND;
          end
        end
        sata_cmd_pkg::CTL_WRITE_SEND: begin
          if (transport_layer_ready) begin
            t_send_data_stb <= 1'b1;
            state           <= sata_cmd_pkg::CTL_WRITE_WAIT_ACT;
          end
        end
        default: begin
          state <= sata_cmd_pkg::CTL_IDLE;
        end
      endcase

      // Device status ends any transfer
      if (t_d2h_reg_stb && state != sata_cmd_pkg::CTL_IDLE) begin
        state        <= sata_cmd_pkg::CTL_IDLE;
        drain_enable <= 1'b0;
      end
      if (soft_reset_en && state != sata_cmd_pkg::CTL_IDLE) begin
        state        <= sata_cmd_pkg::CTL_IDLE;
        drain_enable <= 1'b0;
        sync_escape  <= 1'b1;
      end
      if (send_sync_escape) begin
        state        <= sata_cmd_pkg::CTL_IDLE;
        drain_enable <= 1'b0;
        sync_escape  <= 1'b1;
        busy         <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

// File: sata_command_layer.sv
// SATA command layer top with control FSM, FIS registers and write and read data FIFOs
`timescale 1ns/1ps
`default_nettype none

module sata_command_layer (
  input  logic                             clk,
  input  logic                             reset_timeout,
  input  logic                             transport_layer_ready,
  input  logic                             send_user_command,
  input  logic [sata_cmd_pkg::BYTE_W-1:0]  command,
  input  logic [sata_cmd_pkg::COUNT_W-1:0] user_features,
  input  logic [sata_cmd_pkg::COUNT_W-1:0] sector_count,
  input  logic [sata_cmd_pkg::LBA_W-1:0]   sector_address,
  input  logic                             read_data_en,
  input  logic                             write_data_en,
  input  logic                             single_rdwr,
  input  logic                             soft_reset_en,
  input  logic                             send_sync_escape,
  input  logic                             t_dma_activate_stb,
  input  logic                             t_d2h_reg_stb,
  input  logic                             t_d2h_data_stb,
  input  logic                             t_set_device_bits_stb,
  input  logic [sata_cmd_pkg::LBA_W-1:0]   d2h_lba,
  input  logic [sata_cmd_pkg::BYTE_W-1:0]  d2h_status,
  input  logic [sata_cmd_pkg::DATA_W-1:0]  user_din,
  input  logic                             user_din_valid,
  input  logic                             t_if_ready,
  input  logic [sata_cmd_pkg::DATA_W-1:0]  t_of_data,
  input  logic                             t_of_valid,
  input  logic                             user_dout_ready,
  output logic                             sata_init,
  output logic                             command_layer_ready,
  output logic                             busy,
  output logic                             dev_error,
  output logic [sata_cmd_pkg::BYTE_W-1:0]  device_status,
  output logic                             sync_escape,
  output logic                             t_send_command_stb,
  output logic                             t_send_control_stb,
  output logic                             t_send_data_stb,
  output logic [sata_cmd_pkg::BYTE_W-1:0]  h2d_command,
  output logic [sata_cmd_pkg::COUNT_W-1:0] h2d_features,
  output logic [sata_cmd_pkg::BYTE_W-1:0]  h2d_control,
  output logic [sata_cmd_pkg::LBA_W-1:0]   h2d_lba,
  output logic [sata_cmd_pkg::COUNT_W-1:0] h2d_sector_count,
  output logic                             user_din_ready,
  output logic [sata_cmd_pkg::DATA_W-1:0]  t_if_data,
  output logic                             t_if_valid,
  output logic                             t_of_ready,
  output logic [sata_cmd_pkg::DATA_W-1:0]  user_dout,
  output logic                             user_dout_valid
);

  sata_cmd_pkg::ctl_state_t ctl_state;
  sata_cmd_pkg::cmd_kind_t  cmd_kind;
  logic                     load_cmd;
  logic                     srst;
  logic                     read_first_done;
  logic                     write_first_done;
  logic                     drain_enable;
  logic                     write_fifo_empty;

  sata_cmd_control u_control (
    .clk                   (clk),
    .reset_timeout         (reset_timeout),
    .transport_layer_ready (transport_layer_ready),
    .send_user_command     (send_user_command),
    .read_data_en          (read_data_en),
    .write_data_en         (write_data_en),
    .single_rdwr           (single_rdwr),
    .soft_reset_en         (soft_reset_en),
    .send_sync_escape      (send_sync_escape),
    .t_dma_activate_stb    (t_dma_activate_stb),
    .t_d2h_reg_stb         (t_d2h_reg_stb),
    .t_d2h_data_stb        (t_d2h_data_stb),
    .write_fifo_empty      (write_fifo_empty),
    .state                 (ctl_state),
    .load_cmd              (load_cmd),
    .cmd_kind              (cmd_kind),
    .srst                  (srst),
    .read_first_done       (read_first_done),
    .write_first_done      (write_first_done),
    .drain_enable          (drain_enable),
    .settle_done           (sata_init),
    .command_layer_ready   (command_layer_ready),
    .busy                  (busy),
    .sync_escape           (sync_escape),
    .t_send_command_stb    (t_send_command_stb),
    .t_send_control_stb    (t_send_control_stb),
    .t_send_data_stb       (t_send_data_stb)
  );

  sata_fis_regs u_fis_regs (
    .clk                   (clk),
    .reset_timeout         (reset_timeout),
    .load_cmd              (load_cmd),
    .cmd_kind              (cmd_kind),
    .srst                  (srst),
    .read_first_done       (read_first_done),
    .write_first_done      (write_first_done),
    .read_data_en          (read_data_en),
    .write_data_en         (write_data_en),
    .single_rdwr           (single_rdwr),
    .command               (command),
    .user_features         (user_features),
    .sector_count          (sector_count),
    .sector_address        (sector_address),
    .d2h_lba               (d2h_lba),
    .d2h_status            (d2h_status),
    .t_d2h_reg_stb         (t_d2h_reg_stb),
    .t_set_device_bits_stb (t_set_device_bits_stb),
    .h2d_command           (h2d_command),
    .h2d_features          (h2d_features),
    .h2d_control           (h2d_control),
    .h2d_lba               (h2d_lba),
    .h2d_sector_count      (h2d_sector_count),
    .device_status         (device_status),
    .dev_error             (dev_error)
  );

  // User to transport, drained only after DMA activate
  sata_data_fifo u_write_fifo (
    .clk           (clk),
    .reset_timeout (reset_timeout),
    .in_valid      (user_din_valid),
    .in_data       (user_din),
    .drain_enable  (drain_enable),
    .out_ready     (t_if_ready),
    .in_ready      (user_din_ready),
    .out_valid     (t_if_valid),
    .out_data      (t_if_data),
    .empty         (write_fifo_empty)
  );

  // Transport to user, always drainable
  sata_data_fifo u_read_fifo (
    .clk           (clk),
    .reset_timeout (reset_timeout),
    .in_valid      (t_of_valid),
    .in_data       (t_of_data),
    .drain_enable  (1'b1),
    .out_ready     (user_dout_ready),
    .in_ready      (t_of_ready),
    .out_valid     (user_dout_valid),
    .out_data      (user_dout),
    .empty         ()
  );

endmodule

`default_nettype wire

// File: sata_cmd_asserts.sv
// Concurrent checks on strobe width, write drain gating and busy, bound into the top level
`timescale 1ns/1ps
`default_nettype none

module sata_cmd_asserts (
  input  logic                     clk,
  input  logic                     reset_timeout,
  input  logic                     t_send_command_stb,
  input  logic                     t_send_control_stb,
  input  logic                     t_send_data_stb,
  input  logic                     t_if_valid,
  input  logic                     drain_enable,
  input  sata_cmd_pkg::ctl_state_t state,
  input  logic                     busy,
  input  logic                     t_d2h_reg_stb,
  input  logic                     send_sync_escape
);

  // Transport strobes are single-cycle pulses
  assert property (@(posedge clk) disable iff (!reset_timeout)
    t_send_command_stb |=> !t_send_command_stb)
    else $error("t_send_command_stb wider than one cycle");

  assert property (@(posedge clk) disable iff (!reset_timeout)
    t_send_control_stb |=> !t_send_control_stb)
    else $error("t_send_control_stb wider than one cycle");

  assert property (@(posedge clk) disable iff (!reset_timeout)
    t_send_data_stb |=> !t_send_data_stb)
    else $error("t_send_data_stb wider than one cycle");

  // Write data only leaves while the FSM is in its data phase
  assert property (@(posedge clk) disable iff (!reset_timeout)
    t_if_valid |-> drain_enable && state == sata_cmd_pkg::CTL_WRITE_DATA)
    else $error("t_if_valid outside the write data phase");

  // Busy holds unless the device answers or the link escapes
  assert property (@(posedge clk) disable iff (!reset_timeout)
    t_send_command_stb && !t_d2h_reg_stb && !send_sync_escape |=> busy)
    else $error("busy low after command strobe");

endmodule

bind sata_command_layer sata_cmd_asserts u_asserts (
  .clk                (clk),
  .reset_timeout      (reset_timeout),
  .t_send_command_stb (t_send_command_stb),
  .t_send_control_stb (t_send_control_stb),
  .t_send_data_stb    (t_send_data_stb),
  .t_if_valid         (t_if_valid),
  .drain_enable       (drain_enable),
  .state              (ctl_state),
  .busy               (busy),
  .t_d2h_reg_stb      (t_d2h_reg_stb),
  .send_sync_escape   (send_sync_escape)
);

`default_nettype wire

// File: tb_sata_command_layer.sv
// Testbench top with clock, reset, LFSR data, transport model and directed command layer tests
`timescale 1ns/1ps
`default_nettype none

module tb_sata_command_layer;

  logic        clk;
  logic        reset_timeout;
  logic        transport_layer_ready;
  logic        send_user_command;
  logic [7:0]  command;
  logic [15:0] user_features;
  logic [15:0] sector_count;
  logic [47:0] sector_address;
  logic        read_data_en;
  logic        write_data_en;
  logic        single_rdwr;
  logic        soft_reset_en;
  logic        send_sync_escape;
  logic        t_dma_activate_stb;
  logic        t_d2h_reg_stb;
  logic        t_d2h_data_stb;
  logic        t_set_device_bits_stb;
  logic [47:0] d2h_lba;
  logic [7:0]  d2h_status;
  logic [31:0] user_din;
  logic        user_din_valid;
  logic        t_if_ready;
  logic [31:0] t_of_data;
  logic        t_of_valid;
  logic        user_dout_ready;
  logic        sata_init;
  logic        command_layer_ready;
  logic        busy;
  logic        dev_error;
  logic [7:0]  device_status;
  logic        sync_escape;
  logic        t_send_command_stb;
  logic        t_send_control_stb;
  logic        t_send_data_stb;
  logic [7:0]  h2d_command;
  logic [15:0] h2d_features;
  logic [7:0]  h2d_control;
  logic [47:0] h2d_lba;
  logic [15:0] h2d_sector_count;
  logic        user_din_ready;
  logic [31:0] t_if_data;
  logic        t_if_valid;
  logic        t_of_ready;
  logic [31:0] user_dout;
  logic        user_dout_valid;
  logic [31:0] lfsr_state = 32'hd946_121b;

  sata_command_layer u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("TEST FAIL");
    $fatal(1, "run stopped");
  endtask

  task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%0h expected 0x%0h", name, got, exp);
      stop_run("value mismatch");
    end
  endtask

  // Galois form, taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) begin
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    end
    return b;
  endfunction

  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  function automatic logic level_of(input string name);
    if (name == "command_layer_ready") return command_layer_ready;
    if (name == "t_send_command_stb") return t_send_command_stb;
    if (name == "t_send_control_stb") return t_send_control_stb;
    if (name == "t_send_data_stb") return t_send_data_stb;
    if (name == "sync_escape") return sync_escape;
    if (name == "user_din_ready") return user_din_ready;
    if (name == "t_of_ready") return t_of_ready;
    return 1'b0;
  endfunction

  // Sampled on falling edges, away from the drive edge
  task automatic wait_high(input string name, input int limit);
    int n;
    n = 0;
    @(negedge clk);
    while (!level_of(name)) begin
      n++;
      if (n > limit) begin
        stop_run({"timed out waiting for ", name});
      end
      @(negedge clk);
    end
  endtask

  task automatic count_high(input string name, input int cycles, output int hits);
    hits = 0;
    repeat (cycles) begin
      @(negedge clk);
      if (level_of(name)) hits++;
    end
  endtask

  task automatic reg_fis(input logic [7:0] status, input logic [47:0] lba);
    @(posedge clk);
    d2h_status    <= status;
    d2h_lba       <= lba;
    t_d2h_reg_stb <= 1'b1;
    @(posedge clk);
    t_d2h_reg_stb <= 1'b0;
  endtask

  task automatic reset_test();
    @(negedge clk);
    check_value("busy", 64'(busy), 64'd0);
    check_value("sync_escape", 64'(sync_escape), 64'd0);
    check_value("t_send_command_stb", 64'(t_send_command_stb), 64'd0);
    check_value("t_send_control_stb", 64'(t_send_control_stb), 64'd0);
    check_value("t_send_data_stb", 64'(t_send_data_stb), 64'd0);
    check_value("t_if_valid", 64'(t_if_valid), 64'd0);
    check_value("user_dout_valid", 64'(user_dout_valid), 64'd0);
    check_value("sata_init", 64'(sata_init), 64'd0);
    check_value("command_layer_ready", 64'(command_layer_ready), 64'd0);
    @(posedge clk);
    reset_timeout <= 1'b1;
    wait_high("command_layer_ready", 20);
    check_value("sata_init", 64'(sata_init), 64'd1);
  endtask

  task automatic user_command_test();
    int hits;
    @(posedge clk);
    command           <= 8'hec;
    user_features     <= 16'h1234;
    sector_count      <= 16'h0001;
    sector_address    <= 48'h0000_0a0b_0c0d;
    send_user_command <= 1'b1;
    wait_high("t_send_command_stb", 10);
    check_value("h2d_command", 64'(h2d_command), 64'h00ec);
    check_value("h2d_features", 64'(h2d_features), 64'h1234);
    check_value("h2d_lba", 64'(h2d_lba), 64'h0a0b_0c0d);
    check_value("h2d_sector_count", 64'(h2d_sector_count), 64'h0001);
    count_high("t_send_command_stb", 6, hits);
    check_value("t_send_command_stb extra", 64'(hits), 64'd0);
    check_value("busy", 64'(busy), 64'd1);
    @(posedge clk);
    send_user_command <= 1'b0;
    reg_fis(8'h51, 48'h0);
    @(negedge clk);
    check_value("busy", 64'(busy), 64'd0);
    check_value("device_status", 64'(device_status), 64'h51);
    check_value("dev_error", 64'(dev_error), 64'd1);
  endtask

  task automatic push_user(input logic [31:0] w);
    @(posedge clk);
    user_din       <= w;
    user_din_valid <= 1'b1;
    wait_high("user_din_ready", 20);
    check_value("t_if_valid", 64'(t_if_valid), 64'd0);
  endtask

  task automatic push_transport(input logic [31:0] w);
    @(posedge clk);
    t_of_data  <= w;
    t_of_valid <= 1'b1;
    wait_high("t_of_ready", 20);
  endtask

  task automatic dma_write_test();
    logic [31:0] exp_q[$];
    int          n;
    exp_q.delete();
    @(posedge clk);
    single_rdwr    <= 1'b0;
    sector_count   <= 16'h0008;
    sector_address <= 48'h0000_0000_1000;
    write_data_en  <= 1'b1;
    wait_high("t_send_command_stb", 10);
    check_value("h2d_command", 64'(h2d_command), 64'h35);
    check_value("h2d_lba", 64'(h2d_lba), 64'h1000);
    check_value("h2d_features", 64'(h2d_features), 64'h0);
    for (int i = 0; i < 4; i++) begin
      exp_q.push_back(lfsr_word());
      push_user(exp_q[i]);
    end
    @(posedge clk);
    user_din_valid     <= 1'b0;
    t_dma_activate_stb <= 1'b1;
    @(posedge clk);
    t_dma_activate_stb <= 1'b0;
    n = 0;
    while (exp_q.size() > 0) begin
      @(negedge clk);
      n++;
      if (n > 40) stop_run("write data never drained");
      if (t_if_valid) begin
        check_value("t_if_data", 64'(t_if_data), 64'(exp_q.pop_front()));
      end
    end
    wait_high("t_send_data_stb", 10);
    reg_fis(8'h50, 48'h0000_0000_1007);
    wait_high("t_send_command_stb", 10);
    check_value("h2d_command", 64'(h2d_command), 64'h35);
    check_value("h2d_lba", 64'(h2d_lba), 64'h1008);
    @(posedge clk);
    write_data_en <= 1'b0;
    reg_fis(8'h50, 48'h0000_0000_100f);
    wait_high("command_layer_ready", 10);
  endtask

  task automatic dma_read_test();
    logic [31:0] exp_q[$];
    int          n;
    int          hits;
    exp_q.delete();
    @(posedge clk);
    single_rdwr    <= 1'b1;
    sector_address <= 48'h0000_0002_0000;
    read_data_en   <= 1'b1;
    wait_high("t_send_command_stb", 10);
    check_value("h2d_command", 64'(h2d_command), 64'h25);
    check_value("h2d_lba", 64'(h2d_lba), 64'h2_0000);
    for (int i = 0; i < 6; i++) begin
      exp_q.push_back(lfsr_word());
      push_transport(exp_q[i]);
    end
    @(posedge clk);
    t_of_valid     <= 1'b0;
    t_d2h_data_stb <= 1'b1;
    @(posedge clk);
    t_d2h_data_stb <= 1'b0;
    // Random ready from the user side
    n = 0;
    while (exp_q.size() > 0) begin
      @(posedge clk);
      user_dout_ready <= lfsr_bit();
      @(negedge clk);
      n++;
      if (n > 80) stop_run("read data never reached the user");
      if (user_dout_valid && user_dout_ready) begin
        check_value("user_dout", 64'(user_dout), 64'(exp_q.pop_front()));
      end
    end
    @(posedge clk);
    user_dout_ready <= 1'b0;
    reg_fis(8'h50, 48'h0000_0002_0007);
    count_high("t_send_command_stb", 8, hits);
    check_value("single read requests", 64'(hits), 64'd0);
    @(posedge clk);
    read_data_en <= 1'b0;
    wait_high("command_layer_ready", 10);
  endtask

  task automatic soft_reset_test();
    @(posedge clk);
    soft_reset_en <= 1'b1;
    wait_high("t_send_control_stb", 10);
    check_value("h2d_control", 64'(h2d_control), 64'h04);
    check_value("command_layer_ready", 64'(command_layer_ready), 64'd0);
    // Settling restarts with SRST
    check_value("sata_init", 64'(sata_init), 64'd0);
    @(posedge clk);
    soft_reset_en <= 1'b0;
    wait_high("t_send_control_stb", 20);
    check_value("h2d_control", 64'(h2d_control), 64'h00);
    wait_high("command_layer_ready", 10);
  endtask

  task automatic sync_escape_test();
    @(posedge clk);
    single_rdwr  <= 1'b1;
    read_data_en <= 1'b1;
    wait_high("t_send_command_stb", 10);
    check_value("busy", 64'(busy), 64'd1);
    @(posedge clk);
    send_sync_escape <= 1'b1;
    @(posedge clk);
    send_sync_escape <= 1'b0;
    wait_high("sync_escape", 5);
    check_value("busy", 64'(busy), 64'd0);
    wait_high("command_layer_ready", 10);
    @(posedge clk);
    read_data_en <= 1'b0;
  endtask

  initial begin
    reset_timeout         = 1'b0;
    transport_layer_ready = 1'b1;
    send_user_command     = 1'b0;
    command               = '0;
    user_features         = '0;
    sector_count          = '0;
    sector_address        = '0;
    read_data_en          = 1'b0;
    write_data_en         = 1'b0;
    single_rdwr           = 1'b0;
    soft_reset_en         = 1'b0;
    send_sync_escape      = 1'b0;
    t_dma_activate_stb    = 1'b0;
    t_d2h_reg_stb         = 1'b0;
    t_d2h_data_stb        = 1'b0;
    t_set_device_bits_stb = 1'b0;
    d2h_lba               = '0;
    d2h_status            = '0;
    user_din              = '0;
    user_din_valid        = 1'b0;
    t_if_ready            = 1'b1;
    t_of_data             = '0;
    t_of_valid            = 1'b0;
    user_dout_ready       = 1'b0;
    repeat (9) @(posedge clk);
    reset_test();
    user_command_test();
    dma_write_test();
    dma_read_test();
    soft_reset_test();
    sync_escape_test();
    repeat (2) @(posedge clk);
    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: sata_command_layer.f
sata_cmd_pkg.sv
sata_data_fifo.sv
sata_fis_regs.sv
sata_cmd_control.sv
sata_command_layer.sv
sata_cmd_asserts.sv
tb_sata_command_layer.sv

// File: Makefile
all: run

build:
	verilator --binary --timing --assert -sv -f sata_command_layer.f \
		--top-module tb_sata_command_layer -o sim_tb

run: build
	./obj_dir/sim_tb

lint:
	verilator --lint-only -Wall -sv sata_cmd_pkg.sv sata_data_fifo.sv sata_fis_regs.sv \
		sata_cmd_control.sv sata_command_layer.sv --top-module sata_command_layer

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
